//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module fetch_tb -f verilog.f -o fetch_sim
./obj_dir/fetch_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "test failed" sim.log; then
  exit 1
fi
if ! grep -q "test passed" sim.log; then
  exit 1
fi
exit 0

//--- sim/fetch_model.svh
/*
 * Reference model of the fetch front end.
 * Walks the program image from the expected pc and follows every JAL.
 */

`ifndef FETCH_MODEL_SVH
`define FETCH_MODEL_SVH

localparam int image_words = imem_lines * fetch_width;

logic [31:0] image [image_words];
logic [31:0] model_pc;
int          model_steps;

// J-type immediate rebuilt from the ISA bit layout
function automatic logic [31:0] model_jal_offset(input logic [31:0] word);
  logic [20:0] imm;
  imm = {word[31], word[19:12], word[20], word[30:21], 1'b0};
  return {{11{imm[20]}}, imm};
endfunction

// memory covers 1 KiB, upper pc bits ignored
function automatic logic [31:0] image_word(input logic [31:0] addr);
  return image[addr[9:2]];
endfunction

task automatic model_reset();
  model_pc = 32'h0;
  model_steps = 0;
endtask

task automatic model_redirect(input logic [31:0] target);
  model_pc = target;
endtask

// one taken instruction, then step to the next expected pc
task automatic model_take(input fb_entry_t entry);
  logic [31:0] word;
  word = image_word(model_pc);
  check_value("issued valid", 32'h1, 32'(entry.valid));
  check_value("issued pc", model_pc, entry.pc);
  check_value("issued inst", word, entry.inst);
  if (word[6:0] == rv32_op_jal) begin
    model_pc = model_pc + model_jal_offset(word);
  end else begin
    model_pc = model_pc + 32'd4;
  end
  model_steps++;
endtask

`endif

//--- sim/fetch_tb.sv
/*
 * Testbench for the fetch front end.
 * Random program with JALs, random redirects and decode back-pressure,
 * every taken instruction checked against a reference model.
 */

`timescale 1ns/1ps

module fetch_tb import fetch_pkg::*; ();

  localparam int half_period = 5;
  localparam int reset_cycles = 10;
  localparam int test_cycles = 3000;
  localparam int load_cycles = imem_lines * fetch_width + 1;
  localparam int margin_cycles = 200;
  localparam int timeout_ns =
    (load_cycles + reset_cycles + test_cycles + margin_cycles) * 2 * half_period;
  localparam logic [31:0] wrap_start = 32'h3e0;

  logic        clock;
  logic        reset;
  logic        branch_taken;
  logic [31:0] branch_pc;
  logic        load_en;
  logic [31:0] load_addr;
  logic [31:0] load_word;
  fb_entry_t   inst_out;
  logic        inst_out_valid;
  logic        decode_ready;
  int          errors;
  int          taken;
  int          hold_left;

  fetch_top fetch_top_i (
    .clock          (clock),
    .reset          (reset),
    .branch_taken   (branch_taken),
    .branch_pc      (branch_pc),
    .load_en        (load_en),
    .load_addr      (load_addr),
    .load_word      (load_word),
    .inst_out       (inst_out),
    .inst_out_valid (inst_out_valid),
    .decode_ready   (decode_ready)
  );

  always #half_period clock = ~clock;

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      errors++;
      $display("MISMATCH %s expected %h actual %h", name, expected, actual);
    end
  endtask

  `include "fetch_model.svh"

  // every handshake seen on the decode port
  always @(negedge clock) begin
    if (inst_out_valid && decode_ready) begin
      taken++;
    end
  end

  function automatic logic [31:0] make_jal(input int offset);
    logic [20:0] imm;
    imm = 21'(offset);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, rv32_op_jal};
  endfunction

  // about one word in eight is a JAL, none around the 1 KiB wrap
  task automatic build_image();
    int offset;
    for (int w = 0; w < image_words; w++) begin
      image[w] = $urandom();
      if (image[w][6:0] == rv32_op_jal) begin
        image[w][6:0] = 7'b0010011;
      end
      if (w >= 4 && w < image_words - 8 && $urandom_range(7) == 0) begin
        offset = (int'($urandom_range(128)) - 64) * 4;
        if (offset == 0) begin
          offset = 4;
        end
        image[w] = make_jal(offset);
      end
    end
  endtask

  task automatic load_program();
    for (int w = 0; w < image_words; w++) begin
      @(posedge clock);
      #1;
      load_en = 1'b1;
      load_addr = 32'(w * 4);
      load_word = image[w];
    end
    @(posedge clock);
    #1;
    load_en = 1'b0;
  endtask

  initial begin
    void'($urandom(63532));
    clock = 1'b0;
    reset = 1'b1;
    branch_taken = 1'b0;
    branch_pc = 32'h0;
    load_en = 1'b0;
    load_addr = 32'h0;
    load_word = 32'h0;
    decode_ready = 1'b0;
    errors = 0;
    taken = 0;
    hold_left = 0;
    build_image();
    model_reset();
    // program goes in while the core is held in reset
    load_program();
    repeat (reset_cycles) @(posedge clock);
    #1;
    reset = 1'b0;
    for (int c = 0; c < test_cycles; c++) begin
      @(posedge clock);
      #1;
      branch_taken = 1'b0;
      if (hold_left > 0) begin
        decode_ready = 1'b0;
        hold_left--;
      end else begin
        decode_ready = ($urandom_range(9) < 7);
        // long decode hold to fill the queue
        if ($urandom_range(99) == 0) begin
          hold_left = 20;
        end
      end
      if (taken > 0 && c == test_cycles / 2) begin
        // straight run across the 1 KiB wrap
        branch_taken = 1'b1;
        branch_pc = wrap_start;
      end else if (taken > 0 && $urandom_range(59) == 0) begin
        branch_taken = 1'b1;
        branch_pc = 32'($urandom_range(image_words - 1) * 4);
      end
      @(negedge clock);
      if (branch_taken) begin
        model_redirect(branch_pc);
      end else if (inst_out_valid && decode_ready) begin
        model_take(inst_out);
      end
    end
    @(posedge clock);
    check_value("step count", 32'(model_steps), 32'(taken));
    if (taken < 300) begin
      errors++;
      $display("too few instructions were taken: %0d", taken);
    end
    $display("closing: %0d instructions taken, %0d errors", taken, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin
    #(timeout_ns);
    $display("watchdog expired before the test finished");
    $display("test failed");
    $finish;
  end

endmodule

//--- src/fetch_pkg.sv
/*
 * Fetch front end package.
 * Line geometry, queue sizing, slot and packet structs, JAL decode helpers.
 */

package fetch_pkg;

  // line geometry
  localparam int fetch_width = 4;
  localparam int line_bits = 32 * fetch_width;
  localparam int slot_bits = $clog2(fetch_width);
  // byte offset bits inside one line
  localparam int line_off_bits = slot_bits + 2;

  // instruction memory, 64 lines of 16 bytes
  localparam int imem_lines = 64;
  localparam int line_index_bits = $clog2(imem_lines);

  // fetch queue sizing
  localparam int queue_depth = 4;
  localparam int queue_ptr_bits = $clog2(queue_depth);
  localparam int queue_cnt_bits = $clog2(queue_depth + 1);

  localparam logic [6:0] rv32_op_jal = 7'b1101111;

  // one instruction slot
  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [31:0] inst;
  } fb_entry_t;

  // one fetched line, slot 0 at the lowest address
  typedef struct packed {
    fb_entry_t [fetch_width-1:0] slot;
  } fetch_packet_t;

  // sign-extended J-type immediate
  function automatic logic [31:0] jal_imm(input logic [31:0] inst);
    return {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
  endfunction

  function automatic logic is_jal(input logic [31:0] inst);
    return inst[6:0] == rv32_op_jal;
  endfunction

endpackage

//--- src/fetch_queue.sv
/*
 * Fetch queue.
 * Circular FIFO of any packed payload with flush and an early stall level
 * that leaves one spare entry for the packet already in flight.
 */

`timescale 1ns/1ps

module fetch_queue import fetch_pkg::*; #(
  parameter type entry_t = fetch_packet_t
) (
  input  logic   clock,
  input  logic   reset,
  input  logic   flush,
  input  logic   push,
  input  entry_t push_data,
  input  logic   pop,
  output entry_t head,
  output logic   not_empty,
  output logic   stall
);

  entry_t buffer [queue_depth];

  logic [queue_ptr_bits-1:0] rd_ptr;
  logic [queue_ptr_bits-1:0] wr_ptr;
  logic [queue_cnt_bits-1:0] count;
  logic                      push_en;
  logic                      pop_en;

  function automatic logic [queue_ptr_bits-1:0] ptr_inc(input logic [queue_ptr_bits-1:0] p);
    return (int'(p) == queue_depth - 1) ? '0 : p + 1'b1;
  endfunction

  assign push_en = push & ~flush;
  assign pop_en = pop & ~flush;

  // payload storage
  always_ff @(posedge clock) begin
    if (push_en) begin
      buffer[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_en) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop_en) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({push_en, pop_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign head = buffer[rd_ptr];
  assign not_empty = (count != '0);
  // raised one entry early
  assign stall = (int'(count) >= queue_depth - 1);

  a_no_overflow: assert property (@(posedge clock) disable iff (reset)
    push_en |-> int'(count) < queue_depth);

  a_no_underflow: assert property (@(posedge clock) disable iff (reset)
    pop_en |-> not_empty);

endmodule

//--- src/fetch_top.sv
/*
 * Fetch front end top.
 * Instruction memory, fetch unit, fetch queue and aligner.
 */

`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        branch_taken,
  input  logic [31:0] branch_pc,
  input  logic        load_en,
  input  logic [31:0] load_addr,
  input  logic [31:0] load_word,
  output fb_entry_t   inst_out,
  output logic        inst_out_valid,
  input  logic        decode_ready
);

  logic [31:0]          icache_addr;
  logic [line_bits-1:0] icache_data;
  logic                 icache_data_valid;
  fetch_packet_t        packet;
  logic                 packet_valid;
  fetch_packet_t        head;
  logic                 not_empty;
  logic                 stall;
  logic                 pop;

  inst_mem inst_mem_i (
    .clock             (clock),
    .reset             (reset),
    .icache_addr       (icache_addr),
    .icache_data       (icache_data),
    .icache_data_valid (icache_data_valid),
    .load_en           (load_en),
    .load_addr         (load_addr),
    .load_word         (load_word)
  );

  inst_fetch inst_fetch_i (
    .clock             (clock),
    .reset             (reset),
    .stall             (stall),
    .branch_taken      (branch_taken),
    .branch_pc         (branch_pc),
    .icache_addr       (icache_addr),
    .icache_data       (icache_data),
    .icache_data_valid (icache_data_valid),
    .packet            (packet),
    .packet_valid      (packet_valid)
  );

  // redirect empties everything behind fetch
  fetch_queue #(
    .entry_t (fetch_packet_t)
  ) fetch_queue_i (
    .clock     (clock),
    .reset     (reset),
    .flush     (branch_taken),
    .push      (packet_valid),
    .push_data (packet),
    .pop       (pop),
    .head      (head),
    .not_empty (not_empty),
    .stall     (stall)
  );

  inst_align inst_align_i (
    .clock          (clock),
    .reset          (reset),
    .flush          (branch_taken),
    .head           (head),
    .not_empty      (not_empty),
    .pop            (pop),
    .inst_out       (inst_out),
    .inst_out_valid (inst_out_valid),
    .decode_ready   (decode_ready)
  );

endmodule

//--- src/inst_align.sv
/*
 * Instruction aligner.
 * Walks the live slots of the queue head and issues one per cycle
 * to decode, popping the head after its last live slot is taken.
 */

`timescale 1ns/1ps

module inst_align import fetch_pkg::*; (
  input  logic          clock,
  input  logic          reset,
  input  logic          flush,
  input  fetch_packet_t head,
  input  logic          not_empty,
  output logic          pop,
  output fb_entry_t     inst_out,
  output logic          inst_out_valid,
  input  logic          decode_ready
);

  logic [slot_bits-1:0] idx;
  logic [slot_bits-1:0] sel;
  logic                 found;
  logic                 more;
  logic                 take;

  // lowest live slot at or above idx, and whether another follows it
  always_comb begin
    found = 1'b0;
    more  = 1'b0;
    sel   = '0;
    for (int i = 0; i < fetch_width; i++) begin
      if (i >= int'(idx) && head.slot[i].valid) begin
        if (!found) begin
          found = 1'b1;
          sel   = slot_bits'(i);
        end else begin
          more = 1'b1;
        end
      end
    end
  end

  assign inst_out = head.slot[sel];
  assign inst_out_valid = not_empty & found & ~flush;
  assign take = inst_out_valid & decode_ready;
  assign pop = take & ~more;

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      idx <= '0;
    end else if (pop) begin
      idx <= '0;
    end else if (take) begin
      idx <= sel + 1'b1;
    end
  end

  // held instruction must not change under back-pressure
  a_hold_stable: assert property (@(posedge clock) disable iff (reset || flush)
    inst_out_valid && !decode_ready |=> $stable(inst_out) && inst_out_valid);

endmodule

//--- src/inst_fetch.sv
/*
 * Instruction fetch.
 * Holds the pc, marks live slots of each line and predicts the next pc
 * from the first live JAL or the sequential line.
 */

`timescale 1ns/1ps

module inst_fetch import fetch_pkg::*; (
  input  logic                 clock,
  input  logic                 reset,
  // takes effect one cycle late, queue keeps a spare slot
  input  logic                 stall,
  input  logic                 branch_taken,
  input  logic [31:0]          branch_pc,
  output logic [31:0]          icache_addr,
  input  logic [line_bits-1:0] icache_data,
  input  logic                 icache_data_valid,
  output fetch_packet_t        packet,
  output logic                 packet_valid
);

  logic [31:0]            pc;
  logic [31:0]            pc_aligned;
  logic [slot_bits-1:0]   pc_offset;
  logic [31:0]            pc_predicted;
  logic [fetch_width-1:0] live;
  logic [fetch_width-1:0] slot_jal;

  assign pc_aligned = {pc[31:line_off_bits], {line_off_bits{1'b0}}};
  assign pc_offset = pc[line_off_bits-1:2];
  assign icache_addr = pc_aligned;

  // redirect cycle never pushes
  assign packet_valid = icache_data_valid & ~stall & ~branch_taken;

  // live from the pc offset up to and including the first JAL
  always_comb begin
    logic blocked;
    blocked = 1'b0;
    for (int i = 0; i < fetch_width; i++) begin
      slot_jal[i] = is_jal(icache_data[i*32 +: 32]);
      live[i] = (i >= int'(pc_offset)) && !blocked;
      if (live[i] && slot_jal[i]) begin
        blocked = 1'b1;
      end
    end
  end

  always_comb begin
    for (int i = 0; i < fetch_width; i++) begin
      packet.slot[i].inst  = icache_data[i*32 +: 32];
      packet.slot[i].pc    = pc_aligned + 32'(i * 4);
      packet.slot[i].valid = packet_valid & live[i];
    end
  end

  // at most one live JAL per line, so the loop order does not matter
  always_comb begin
    pc_predicted = pc_aligned + 32'(fetch_width * 4);
    for (int i = 0; i < fetch_width; i++) begin
      if (live[i] && slot_jal[i]) begin
        pc_predicted = packet.slot[i].pc + jal_imm(packet.slot[i].inst);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= 32'h0;
    end else if (branch_taken) begin
      pc <= branch_pc;
    end else if (packet_valid) begin
      pc <= pc_predicted;
    end
  end

  // a new line address must not see the old line as valid
  a_no_stale_line: assert property (@(posedge clock) disable iff (reset)
    icache_addr != $past(icache_addr) |-> !icache_data_valid);

endmodule

//--- src/inst_mem.sv
/*
 * Instruction memory.
 * Word-wide load port, line-wide read one cycle after the address,
 * valid while the registered address matches the current one.
 */

`timescale 1ns/1ps

module inst_mem import fetch_pkg::*; (
  input  logic                 clock,
  input  logic                 reset,
  input  logic [31:0]          icache_addr,
  output logic [line_bits-1:0] icache_data,
  output logic                 icache_data_valid,
  input  logic                 load_en,
  input  logic [31:0]          load_addr,
  input  logic [31:0]          load_word
);

  logic [31:0] mem [imem_lines*fetch_width];
  logic [31:0] addr_q;
  logic [line_index_bits-1:0] rd_line;

  // word writes from the testbench, upper address bits wrap
  always_ff @(posedge clock) begin
    if (load_en) begin
      mem[load_addr[2 +: line_index_bits + slot_bits]] <= load_word;
    end
  end

  // odd reset value so no aligned address matches
  always_ff @(posedge clock) begin
    if (reset) begin
      addr_q <= 32'hffff_ffff;
    end else begin
      addr_q <= icache_addr;
    end
  end

  assign rd_line = addr_q[line_off_bits +: line_index_bits];

  always_comb begin
    for (int w = 0; w < fetch_width; w++) begin
      icache_data[w*32 +: 32] = mem[{rd_line, slot_bits'(w)}];
    end
  end

  assign icache_data_valid = (addr_q == icache_addr);

  // loading the line being fetched would corrupt the packet
  a_no_load_on_read: assert property (@(posedge clock) disable iff (reset)
    load_en |-> load_addr[line_off_bits +: line_index_bits]
                != icache_addr[line_off_bits +: line_index_bits]);

endmodule

//--- verilog.f
+incdir+sim
src/fetch_pkg.sv
src/inst_mem.sv
src/inst_fetch.sv
src/fetch_queue.sv
src/inst_align.sv
src/fetch_top.sv
sim/fetch_tb.sv
